/* common/div_pkg.sv */
/*
  Shared types and constants for the integer divide unit.
  Modules pull these in with a wildcard import in their header.
*/
`default_nettype none

package div_pkg;

  // ============================================================
  // widths
  // ============================================================
  localparam int unsigned XLEN  = 64;  // register width
  localparam int unsigned WLEN  = 32;  // operand width of the *w forms
  localparam int unsigned CNT_W = 7;   // counts down from 64

  // ============================================================
  // iteration counts, one quotient bit per pass
  // ============================================================
  localparam logic [CNT_W-1:0] ITER_D = CNT_W'(64);  // doubleword
  localparam logic [CNT_W-1:0] ITER_W = CNT_W'(32);  // word

  // ============================================================
  // opcodes
  // ============================================================
  // one-hot, bit 7 is div and bit 0 is remw
  typedef enum logic [7:0] {
    OP_NONE = 8'b0000_0000,
    DIV     = 8'b1000_0000,  // signed 64
    DIVU    = 8'b0100_0000,  // unsigned 64
    DIVUW   = 8'b0010_0000,  // unsigned 32
    DIVW    = 8'b0001_0000,  // signed 32
    REM     = 8'b0000_1000,  // signed 64
    REMU    = 8'b0000_0100,  // unsigned 64
    REMUW   = 8'b0000_0010,  // unsigned 32
    REMW    = 8'b0000_0001   // signed 32
  } div_op_e;

  // ============================================================
  // core FSM
  // ============================================================
  typedef enum logic [1:0] {
    IDLE   = 2'b00,  // waiting for a request
    DO_DIV = 2'b01,  // shift-subtract loop
    FINISH = 2'b10   // result held for the consumer
  } div_state_e;

endpackage

`default_nettype wire

/* common/div_op_if.sv */
/*
  Prepared operation handed from the operand stage to the iteration core.
  Driven continuously by the prep block and sampled by the core on accept.
*/
`default_nettype none

interface div_op_if import div_pkg::*; ();

  div_op_e          op;          // request opcode
  logic             exc;         // divide by zero or overflow
  logic [XLEN-1:0]  exc_result;  // architected result for exc
  logic [XLEN-1:0]  dvd_mag;     // dividend magnitude, word ops left aligned
  logic [XLEN-1:0]  dvs_mag;     // divisor magnitude
  logic [CNT_W-1:0] iter;        // passes needed
  logic             q_neg;       // quotient must be negated
  logic             r_neg;       // remainder must be negated

  modport prep (
    output op, exc, exc_result, dvd_mag, dvs_mag, iter, q_neg, r_neg
  );

  modport core (
    input  op, exc, exc_result, dvd_mag, dvs_mag, iter, q_neg, r_neg
  );

endinterface

`default_nettype wire

/* divider/div_prep.sv */
/*
  Operand stage of the divide unit. Purely combinational.
  Works out magnitudes, result signs and the divide-by-zero and
  overflow shortcuts, and presents them on the operation interface.
*/
`default_nettype none

module div_prep import div_pkg::*; (
  input  div_op_e         div_op_i,
  input  logic [XLEN-1:0] dividend_i,
  input  logic [XLEN-1:0] divisor_i,
  div_op_if.prep          prep_o
);

  logic            op_ok;      // exactly one opcode bit
  logic            is_word;
  logic            is_signed;
  logic            is_rem;

  logic [XLEN-1:0] dvd_sext;   // low word sign extended
  logic [XLEN-1:0] dvs_sext;
  logic [XLEN-1:0] dvd_ext;    // operand as the opcode sees it
  logic [XLEN-1:0] dvs_ext;
  logic            dvd_neg;
  logic            dvs_neg;
  logic [XLEN-1:0] dvd_abs;
  logic [XLEN-1:0] dvs_abs;
  logic [XLEN-1:0] dvd_res;    // dividend as returned by the shortcuts
  logic            div_zero;
  logic            div_ovf;
  logic [XLEN-1:0] exc_res;

  // ============================================================
  // opcode decode
  // ============================================================
  assign op_ok     = $onehot(div_op_i);
  assign is_word   = div_op_i inside {DIVUW, DIVW, REMUW, REMW};
  assign is_signed = div_op_i inside {DIV, DIVW, REM, REMW};
  assign is_rem    = div_op_i inside {REM, REMU, REMUW, REMW};

  // ============================================================
  // operands and magnitudes
  // ============================================================
  assign dvd_sext = {{(XLEN-WLEN){dividend_i[WLEN-1]}}, dividend_i[WLEN-1:0]};
  assign dvs_sext = {{(XLEN-WLEN){divisor_i[WLEN-1]}}, divisor_i[WLEN-1:0]};

  always_comb begin : operand_sel
    if (!is_word) begin
      dvd_ext = dividend_i;
      dvs_ext = divisor_i;
    end else if (is_signed) begin
      dvd_ext = dvd_sext;
      dvs_ext = dvs_sext;
    end else begin
      // unsigned word forms see only the low half
      dvd_ext = {{(XLEN-WLEN){1'b0}}, dividend_i[WLEN-1:0]};
      dvs_ext = {{(XLEN-WLEN){1'b0}}, divisor_i[WLEN-1:0]};
    end
  end

  assign dvd_neg = is_signed & dvd_ext[XLEN-1];
  assign dvs_neg = is_signed & dvs_ext[XLEN-1];
  assign dvd_abs = dvd_neg ? (~dvd_ext + 1'b1) : dvd_ext;
  assign dvs_abs = dvs_neg ? (~dvs_ext + 1'b1) : dvs_ext;

  // ============================================================
  // shortcut detection
  // ============================================================
  assign div_zero = is_word ? (divisor_i[WLEN-1:0] == '0) : (divisor_i == '0);
  // most negative value over minus one, word forms via their sign extension
  assign div_ovf  = is_signed & (dvs_ext == '1) &
                    (dvd_ext == (is_word ? {{(XLEN-WLEN+1){1'b1}}, {(WLEN-1){1'b0}}}
                                         : {1'b1, {(XLEN-1){1'b0}}}));
  assign dvd_res  = is_word ? dvd_sext : dividend_i;

  always_comb begin : exc_sel
    exc_res = '0;
    if (div_zero) begin
      exc_res = is_rem ? dvd_res : '1;
    end else if (div_ovf) begin
      exc_res = is_rem ? '0 : dvd_res;
    end
  end

  // ============================================================
  // interface drive
  // ============================================================
  assign prep_o.op         = div_op_i;
  assign prep_o.exc        = op_ok & (div_zero | div_ovf);
  assign prep_o.exc_result = exc_res;
  assign prep_o.dvd_mag    = is_word ? {dvd_abs[WLEN-1:0], {(XLEN-WLEN){1'b0}}} : dvd_abs;
  assign prep_o.dvs_mag    = dvs_abs;
  assign prep_o.iter       = is_word ? ITER_W : ITER_D;
  assign prep_o.q_neg      = dvd_neg ^ dvs_neg;  // signs differ
  assign prep_o.r_neg      = dvd_neg;            // follows the dividend

  // the loop must never start on a zero divisor
  always_comb begin : chk_normal_path
    if (op_ok && !prep_o.exc) begin
      assert final (dvs_abs != '0)
        else $error("div_prep: zero divisor magnitude on normal path");
    end
  end

endmodule

`default_nettype wire

/* divider/div_core.sv */
/*
  Iteration core of the divide unit. Restoring shift-subtract on magnitudes,
  one quotient bit per cycle, with a 128-bit remainder and quotient register.
  Shortcut results go straight to FINISH. Results wait there for ready.
*/
`default_nettype none

module div_core import div_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            div_valid_i,
  input  logic            result_ready_i,
  div_op_if.core          op_i,
  output logic            div_stall_o,
  output logic            result_ok_o,
  output logic [XLEN-1:0] quo_o,
  output logic [XLEN-1:0] rem_o,
  output div_op_e         op_o,
  output logic            q_neg_o,
  output logic            r_neg_o
);

  div_state_e        state_q;
  logic [CNT_W-1:0]  cnt_q;     // passes left
  logic [2*XLEN-1:0] rq_q;      // {remainder, quotient}
  logic [XLEN-1:0]   dvs_q;     // divisor magnitude
  div_op_e           op_q;
  logic              q_neg_q;
  logic              r_neg_q;

  logic              accept;
  logic              iterate;
  logic [XLEN:0]     partial;   // shifted remainder with its carry bit
  logic [XLEN:0]     diff;
  logic              fits;      // divisor goes into partial

  assign accept  = (state_q == IDLE) && div_valid_i && $onehot(op_i.op);
  assign iterate = (state_q == DO_DIV) && (cnt_q != '0);

  // ============================================================
  // one restoring step
  // ============================================================
  assign partial = rq_q[2*XLEN-1:XLEN-1];
  assign diff    = partial - {1'b0, dvs_q};
  assign fits    = ~diff[XLEN];  // no borrow

  // ============================================================
  // FSM and counter
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q <= IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            if (op_i.exc) begin
              state_q <= FINISH;  // shortcut result already known
            end else begin
              state_q <= DO_DIV;
              cnt_q   <= op_i.iter;
            end
          end
        end
        DO_DIV: begin
          if (cnt_q == '0) begin
            state_q <= FINISH;  // terminal count
          end else begin
            cnt_q <= cnt_q - 1'b1;
          end
        end
        FINISH: begin
          if (result_ready_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // ============================================================
  // datapath
  // ============================================================
  always_ff @(posedge clk) begin
    if (accept) begin
      rq_q    <= {{XLEN{1'b0}}, (op_i.exc ? op_i.exc_result : op_i.dvd_mag)};
      dvs_q   <= op_i.dvs_mag;
      // OP_NONE makes the formatter pass the shortcut result as is
      op_q    <= op_i.exc ? OP_NONE : op_i.op;
      q_neg_q <= ~op_i.exc & op_i.q_neg;
      r_neg_q <= ~op_i.exc & op_i.r_neg;
    end else if (iterate) begin
      rq_q <= {(fits ? diff[XLEN-1:0] : partial[XLEN-1:0]), rq_q[XLEN-2:0], fits};
    end
  end

  // ============================================================
  // outputs
  // ============================================================
  assign div_stall_o = (accept && !op_i.exc) || (state_q == DO_DIV);
  assign result_ok_o = (state_q == FINISH);
  assign quo_o       = rq_q[XLEN-1:0];
  assign rem_o       = rq_q[2*XLEN-1:XLEN];
  assign op_o        = op_q;
  assign q_neg_o     = q_neg_q;
  assign r_neg_o     = r_neg_q;

  // ============================================================
  // checks
  // ============================================================
  a_ok_stall_excl: assert property (@(posedge clk) disable iff (rst_n)
    !(result_ok_o && div_stall_o));

  // counter steps down by one and leaves DO_DIV at zero, never wrapping
  a_cnt_step: assert property (@(posedge clk) disable iff (rst_n)
    iterate |=> (state_q == DO_DIV) && (cnt_q == $past(cnt_q) - 1'b1));

  a_cnt_end: assert property (@(posedge clk) disable iff (rst_n)
    (state_q == DO_DIV && cnt_q == '0) |=> (state_q == FINISH));

  // result frozen while the consumer holds off
  a_hold: assert property (@(posedge clk) disable iff (rst_n)
    (state_q == FINISH && !result_ready_i) |=> (state_q == FINISH) && $stable(rq_q));

endmodule

`default_nettype wire

/* divider/div_result_fmt.sv */
/*
  Result formatter of the divide unit. Combinational.
  Picks quotient or remainder by opcode, puts the sign back and
  sign-extends the word forms. Shortcut results pass through.
*/
`default_nettype none

module div_result_fmt import div_pkg::*; (
  input  div_op_e         op_i,
  input  logic [XLEN-1:0] quo_i,
  input  logic [XLEN-1:0] rem_i,
  input  logic            q_neg_i,
  input  logic            r_neg_i,
  output logic [XLEN-1:0] result_o
);

  logic [XLEN-1:0] quo_s;  // signed quotient
  logic [XLEN-1:0] rem_s;  // signed remainder

  function automatic logic [XLEN-1:0] sext_w(input logic [XLEN-1:0] v);
    return {{(XLEN-WLEN){v[WLEN-1]}}, v[WLEN-1:0]};
  endfunction

  assign quo_s = q_neg_i ? (~quo_i + 1'b1) : quo_i;
  assign rem_s = r_neg_i ? (~rem_i + 1'b1) : rem_i;

  // unsigned forms arrive with both sign flags clear
  always_comb begin : sel
    case (op_i)
      DIV, DIVU:   result_o = quo_s;
      DIVW, DIVUW: result_o = sext_w(quo_s);
      REM, REMU:   result_o = rem_s;
      REMW, REMUW: result_o = sext_w(rem_s);
      default:     result_o = quo_i;  // shortcut result, already final
    endcase
  end

endmodule

`default_nettype wire

/* hdl/div_unit_top.sv */
/*
  Top level of the integer divide unit for the RV64M divide ops.
  Plain request and result ports. One operation in flight at a time.
*/
`default_nettype none

module div_unit_top import div_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,           // synchronous, active high
  input  logic            div_valid_i,
  input  div_op_e         div_op_i,
  input  logic [XLEN-1:0] dividend_i,
  input  logic [XLEN-1:0] divisor_i,
  input  logic            result_ready_i,
  output logic [XLEN-1:0] result_o,
  output logic            result_ok_o,
  output logic            div_stall_o
);

  logic [XLEN-1:0] quo;
  logic [XLEN-1:0] rem;
  div_op_e         op_l;   // opcode latched in the core
  logic            q_neg;
  logic            r_neg;

  div_op_if op_bus ();

  div_prep u_prep (
    .div_op_i   (div_op_i),
    .dividend_i (dividend_i),
    .divisor_i  (divisor_i),
    .prep_o     (op_bus.prep)
  );

  div_core u_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .result_ready_i (result_ready_i),
    .op_i           (op_bus.core),
    .div_stall_o    (div_stall_o),
    .result_ok_o    (result_ok_o),
    .quo_o          (quo),
    .rem_o          (rem),
    .op_o           (op_l),
    .q_neg_o        (q_neg),
    .r_neg_o        (r_neg)
  );

  div_result_fmt u_fmt (
    .op_i     (op_l),
    .quo_i    (quo),
    .rem_i    (rem),
    .q_neg_i  (q_neg),
    .r_neg_i  (r_neg),
    .result_o (result_o)
  );

endmodule

`default_nettype wire

/* tb/div_ref_model.svh */
/*
  Reference results for the RV64M divide ops, worked out from the ISA rules.
  Included in the body of the testbench module, after the package import.
*/
`ifndef DIV_REF_MODEL_SVH
`define DIV_REF_MODEL_SVH

function automatic logic is_word_op(input div_op_e op);
  return op inside {DIVW, DIVUW, REMW, REMUW};
endfunction

function automatic logic [63:0] sext_word(input logic [31:0] v);
  return {{32{v[31]}}, v};
endfunction

// most negative dividend over minus one, signed ops only
function automatic logic overflows(input div_op_e op, input logic [63:0] a, b);
  case (op)
    DIV, REM:   return (a == 64'h8000_0000_0000_0000) && (b == '1);
    DIVW, REMW: return (a[31:0] == 32'h8000_0000) && (b[31:0] == 32'hFFFF_FFFF);
    default:    return 1'b0;
  endcase
endfunction

function automatic logic divides_by_zero(input div_op_e op, input logic [63:0] b);
  return is_word_op(op) ? (b[31:0] == 32'h0) : (b == 64'h0);
endfunction

// cycles from driving the request to result_ok_o
function automatic int expected_latency(input div_op_e op, input logic [63:0] a, b);
  if (divides_by_zero(op, b) || overflows(op, a, b)) return 1;
  return is_word_op(op) ? 34 : 66;
endfunction

function automatic logic [63:0] expected_result(input div_op_e op, input logic [63:0] a, b);
  logic signed [63:0] sa;
  logic signed [63:0] sb;
  logic signed [31:0] wa;
  logic signed [31:0] wb;
  sa = a;
  sb = b;
  wa = a[31:0];
  wb = b[31:0];
  if (divides_by_zero(op, b)) begin
    case (op)
      REM, REMU:   return a;  // remainder is the dividend
      REMW, REMUW: return sext_word(a[31:0]);
      default:     return '1;
    endcase
  end
  if (overflows(op, a, b)) return (op == DIV) ? a : (op == DIVW) ? sext_word(a[31:0]) : '0;
  case (op)
    DIV:     return sa / sb;  // truncates toward zero
    DIVU:    return a / b;
    REM:     return sa % sb;  // takes the dividend sign
    REMU:    return a % b;
    DIVW:    return sext_word(wa / wb);
    DIVUW:   return sext_word(a[31:0] / b[31:0]);
    REMW:    return sext_word(wa % wb);
    default: return sext_word(a[31:0] % b[31:0]);
  endcase
endfunction

`endif

/* tb/div_tb.sv */
/*
  Testbench for the integer divide unit. LFSR operands run through all
  eight divide ops with back-pressure; concurrent assertions compare the
  results with the reference functions and check the timing.
*/
`default_nettype none

module div_tb import div_pkg::*; ();

  logic            clk;
  logic            rst_n;
  logic            div_valid_i;
  div_op_e         div_op_i;
  logic [XLEN-1:0] dividend_i;
  logic [XLEN-1:0] divisor_i;
  logic            result_ready_i;
  logic [XLEN-1:0] result_o;
  logic            result_ok_o;
  logic            div_stall_o;

  logic [15:0]     lfsr_q;
  logic [XLEN-1:0] exp_result;
  int              exp_lat;   // edges from drive to result_ok_o
  logic            exp_exc;
  logic            launch;    // request driven this cycle
  logic            pending;   // request not yet handed over
  logic            started;
  int              lat_cnt;

  `include "div_ref_model.svh"

  div_unit_top uut (.*);

  always #10 clk = ~clk;

  always @(posedge clk) lat_cnt <= launch ? 1 : lat_cnt + 1;

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic abort_timeout(input string msg);
    $display("timeout at %0t: %s", $time, msg);
    $display("ERRORS FOUND");
    $fatal(1, "stopping after a timeout");
  endtask

  // ============================================================
  // checks
  // ============================================================
  a_reset: assert property (@(posedge clk) rst_n |=> !result_ok_o && !div_stall_o)
    else report_mismatch("outputs not low after reset");
  a_idle: assert property (@(posedge clk) disable iff (rst_n)
    !started |-> !result_ok_o && !div_stall_o)
    else report_mismatch("activity before the first valid request");
  a_value: assert property (@(posedge clk) disable iff (rst_n)
    result_ok_o |-> result_o == exp_result)
    else report_mismatch($sformatf("result %h, expected %h", result_o, exp_result));
  a_latency: assert property (@(posedge clk) disable iff (rst_n)
    $rose(result_ok_o) |-> lat_cnt == exp_lat)
    else report_mismatch($sformatf("wrong result latency, expected %0d cycles", exp_lat));
  a_busy: assert property (@(posedge clk) disable iff (rst_n)
    (pending && !exp_exc && !result_ok_o) |-> div_stall_o)
    else report_mismatch("div_stall_o low while an operation runs");
  a_exc: assert property (@(posedge clk) disable iff (rst_n) (pending && exp_exc) |-> !div_stall_o)
    else report_mismatch("div_stall_o raised on the exception path");
  a_hold: assert property (@(posedge clk) disable iff (rst_n)
    (result_ok_o && !result_ready_i) |=> result_ok_o && $stable(result_o))
    else report_mismatch("result changed while result_ready_i was low");
  a_release: assert property (@(posedge clk) disable iff (rst_n)
    (result_ok_o && result_ready_i) |=> !result_ok_o)
    else report_mismatch("result_ok_o still high after result_ready_i");

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [XLEN-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[XLEN-2:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic run_op(input div_op_e op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    int              n;
    logic [XLEN-1:0] hold;
    exp_result = expected_result(op, a, b);
    exp_lat    = expected_latency(op, a, b);
    exp_exc    = (exp_lat == 1);
    div_op_i   = op;
    dividend_i = a;
    divisor_i  = b;
    {div_valid_i, launch, pending, started} = 4'b1111;
    @(posedge clk);
    #1;
    {div_valid_i, launch} = 2'b00;
    n = 1;
    while (!result_ok_o && n < 100) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (!result_ok_o) abort_timeout("result_ok_o never rose");
    take_bits(3, hold);  // consumer holds off 0 to 7 cycles
    for (int i = 0; i < int'(hold); i++) begin
      div_valid_i = (i == 0);  // stray request, must be ignored
      div_op_i    = DIVU;
      @(posedge clk);
      #1;
    end
    {div_valid_i, result_ready_i} = 2'b01;
    n = 0;
    do begin
      @(posedge clk);
      #1;
      n++;
    end while (result_ok_o && n < 4);
    if (result_ok_o) abort_timeout("result_ok_o stayed high after result_ready_i");
    {result_ready_i, pending} = 2'b00;
  endtask

  initial begin : stimulus
    div_op_e         all_ops [8];
    div_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] w;
    logic [XLEN-1:0] hi;
    all_ops = '{DIVU, REMU, DIV, REM, DIVW, DIVUW, REMW, REMUW};
    {clk, rst_n, div_valid_i, result_ready_i} = 4'b0100;
    div_op_i   = OP_NONE;
    dividend_i = '0;
    divisor_i  = '0;
    {launch, pending, started, exp_exc, exp_lat, exp_result} = '0;
    lfsr_q = 16'd65;
    repeat (2) @(posedge clk);
    #1;
    rst_n       = 1'b0;
    div_valid_i = 1'b1;  // OP_NONE is not a request
    @(posedge clk);
    #1;
    div_valid_i = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    // ============================================================
    // random operands, four sign combinations per op
    // ============================================================
    for (int s = 0; s < 32; s++) begin
      op = all_ops[s / 4];
      take_bits(64, a);
      take_bits(is_word_op(op) ? 5 : 6, w);
      take_bits(int'(w) + 1, b);
      if (is_word_op(op)) begin
        take_bits(32, hi);
        b     = {hi[31:0], b[31:0]};  // upper half is don't care
        a[31] = s[0];
        if (s[1]) b[31:0] = -b[31:0];
      end else begin
        a[63] = s[0];
        if (s[1]) b = -b;
      end
      run_op(op, a, b);
    end
    // ============================================================
    // zero divisor and overflow for every op
    // ============================================================
    for (int k = 0; k < 8; k++) begin
      op = all_ops[k];
      take_bits(64, a);
      take_bits(64, hi);
      run_op(op, a, is_word_op(op) ? {hi[31:0], 32'h0} : '0);
      run_op(op, is_word_op(op) ? {hi[31:0], 32'h8000_0000} : {1'b1, 63'h0},
             is_word_op(op) ? {hi[63:32], 32'hFFFF_FFFF} : '1);
    end
    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
+incdir+tb
common/div_pkg.sv
common/div_op_if.sv
divider/div_prep.sv
divider/div_core.sv
divider/div_result_fmt.sv
hdl/div_unit_top.sv
tb/div_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the divide unit testbench with Verilator and runs it.
# Exits nonzero when the build fails or the log shows a failure.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module div_tb -f sources.f -o div_sim \
  || { echo "build failed"; exit 1; }

./obj_dir/div_sim > "$LOG" 2>&1
cat "$LOG"

grep -q "ERRORS FOUND" "$LOG" && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" "$LOG" || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
